// ==== Bender.yml ====
package:
  name: exu

sources:
  - include_dirs:
      - hw
    files:
      - hw/exu_pkg.sv
      - hw/alu_core.sv
      - hw/mul_iter.sv
      - hw/div_iter.sv
      - hw/exu_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/exu_props.sv
      - sim/exu_checker.sv
      - sim/exu_tb.sv

// ==== hw/alu_core.sv ====
`timescale 1ns/1ps
`include "exu_config.svh"

module alu_core (
  input  exu_pkg::alu_op_e     alu_op_i,
  input  logic                 word_i,
  input  logic [`EXU_XLEN-1:0] src1_i,
  input  logic [`EXU_XLEN-1:0] src2_i,
  output logic [`EXU_XLEN-1:0] res_o
);
  localparam int XLEN = `EXU_XLEN;
  localparam int HALF = XLEN / 2;
  localparam int SW   = $clog2(XLEN);

  logic            sub_en;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] op_b_inv;
  logic [XLEN-1:0] sum;
  logic            carry;
  logic            ovf;
  logic            less;
  logic [SW-1:0]   shamt;
  logic [XLEN-1:0] sh_src;
  logic [XLEN-1:0] sh_rev;
  logic [XLEN-1:0] sh_in;
  logic [XLEN-1:0] sh_out;
  logic [XLEN-1:0] sll_res;
  logic [XLEN-1:0] mask;
  logic [XLEN-1:0] fill;
  logic [XLEN-1:0] res;

  // shared adder, word operands sign-extended so slt/sltu compare 32 bits
  always_comb begin
    op_a = word_i ? {{HALF{src1_i[HALF-1]}}, src1_i[HALF-1:0]} : src1_i;
    op_b = word_i ? {{HALF{src2_i[HALF-1]}}, src2_i[HALF-1:0]} : src2_i;
    sub_en = (alu_op_i == exu_pkg::ALU_SUB) || (alu_op_i == exu_pkg::ALU_SLT) ||
             (alu_op_i == exu_pkg::ALU_SLTU);
    op_b_inv = op_b ^ {XLEN{sub_en}};
    {carry, sum} = {1'b0, op_a} + {1'b0, op_b_inv} + {{XLEN{1'b0}}, sub_en};
    ovf = (op_a[XLEN-1] == op_b_inv[XLEN-1]) && (sum[XLEN-1] != op_a[XLEN-1]);
    // no carry out of a - b means a borrow
    less = (alu_op_i == exu_pkg::ALU_SLTU) ? ~carry : (sum[XLEN-1] ^ ovf);
  end

  // right shifter only, left shift goes through bit reversal
  always_comb begin
    shamt  = word_i ? {1'b0, src2_i[SW-2:0]} : src2_i[SW-1:0];
    sh_src = word_i ? {{HALF{1'b0}}, src1_i[HALF-1:0]} : src1_i;
    for (int i = 0; i < XLEN; i++) begin
      sh_rev[i] = sh_src[XLEN-1-i];
    end
    sh_in  = (alu_op_i == exu_pkg::ALU_SLL) ? sh_rev : sh_src;
    sh_out = sh_in >> shamt;
    for (int i = 0; i < XLEN; i++) begin
      sll_res[i] = sh_out[XLEN-1-i];
    end
    // fill mask for sra, word form uses the upper half as a 32-bit mask
    mask = {XLEN{1'b1}} >> shamt;
    if (word_i) begin
      fill = {{HALF{1'b0}}, ~mask[XLEN-1:HALF]} & {XLEN{src1_i[HALF-1]}};
    end else begin
      fill = ~mask & {XLEN{src1_i[XLEN-1]}};
    end
  end

  always_comb begin
    case (alu_op_i)
      exu_pkg::ALU_ADD,
      exu_pkg::ALU_SUB:  res = sum;
      exu_pkg::ALU_SLL:  res = sll_res;
      exu_pkg::ALU_SLT,
      exu_pkg::ALU_SLTU: res = {{(XLEN-1){1'b0}}, less};
      exu_pkg::ALU_PASS: res = src2_i;
      exu_pkg::ALU_XOR:  res = src1_i ^ src2_i;
      exu_pkg::ALU_SRL:  res = sh_out;
      exu_pkg::ALU_SRA:  res = sh_out | fill;
      exu_pkg::ALU_OR:   res = src1_i | src2_i;
      exu_pkg::ALU_AND:  res = src1_i & src2_i;
      default:           res = '0;
    endcase
  end

  // word results sign-extended from bit 31
  assign res_o = word_i ? {{HALF{res[HALF-1]}}, res[HALF-1:0]} : res;

endmodule

// ==== hw/div_iter.sv ====
`timescale 1ns/1ps
`include "exu_config.svh"

module div_iter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start_i,
  input  logic                 flush_i,
  input  exu_pkg::md_op_e      op_i,
  input  logic [`EXU_XLEN-1:0] src1_i,
  input  logic [`EXU_XLEN-1:0] src2_i,
  output logic                 done_o,
  output logic [`EXU_XLEN-1:0] result_o
);
  localparam int XLEN  = `EXU_XLEN;
  localparam int CNT_W = $clog2(`EXU_MD_CYCLES);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`EXU_MD_CYCLES - 1);

  exu_pkg::md_state_e state_q;
  logic [CNT_W-1:0]   cnt_q;
  logic [XLEN-1:0]    quo_q;
  logic [XLEN-1:0]    rem_q;
  logic [XLEN-1:0]    dsr_q;
  logic [XLEN-1:0]    dvd_q;
  logic               q_neg_q;
  logic               r_neg_q;
  logic               rem_sel_q;
  logic               div0_q;
  logic               ovf_q;
  logic               signed_op;
  logic               a_neg;
  logic               b_neg;
  logic [XLEN:0]      rem_sh;
  logic [XLEN+1:0]    trial;
  logic               fits;
  logic [XLEN-1:0]    quo_fix;
  logic [XLEN-1:0]    rem_fix;

  always_comb begin
    signed_op = (op_i == exu_pkg::MD_DIV) || (op_i == exu_pkg::MD_REM);
    a_neg     = signed_op && src1_i[XLEN-1];
    b_neg     = signed_op && src2_i[XLEN-1];
  end

  // one restoring step, keep the difference only when it does not borrow
  always_comb begin
    rem_sh = {rem_q, quo_q[XLEN-1]};
    trial  = {1'b0, rem_sh} - {2'b00, dsr_q};
    fits   = ~trial[XLEN+1];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= exu_pkg::MD_IDLE;
      cnt_q   <= '0;
    end else if (flush_i) begin
      state_q <= exu_pkg::MD_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        exu_pkg::MD_IDLE: begin
          if (start_i) begin
            state_q <= exu_pkg::MD_RUN;
            cnt_q   <= '0;
          end
        end
        exu_pkg::MD_RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == LAST) begin
            state_q <= exu_pkg::MD_DONE;
          end
        end
        default: state_q <= exu_pkg::MD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == exu_pkg::MD_IDLE) && start_i) begin
      quo_q     <= a_neg ? -src1_i : src1_i;
      rem_q     <= '0;
      dsr_q     <= b_neg ? -src2_i : src2_i;
      dvd_q     <= src1_i;
      q_neg_q   <= a_neg ^ b_neg;
      r_neg_q   <= a_neg;
      rem_sel_q <= (op_i == exu_pkg::MD_REM) || (op_i == exu_pkg::MD_REMU);
      div0_q    <= (src2_i == '0);
      // most negative dividend over minus one
      ovf_q     <= signed_op && (src1_i == {1'b1, {(XLEN-1){1'b0}}}) && (src2_i == '1);
    end else if (state_q == exu_pkg::MD_RUN) begin
      rem_q <= fits ? trial[XLEN-1:0] : rem_sh[XLEN-1:0];
      quo_q <= {quo_q[XLEN-2:0], fits};
    end
  end

  // sign fix-up, then the RISC-V special cases override
  always_comb begin
    quo_fix = q_neg_q ? -quo_q : quo_q;
    rem_fix = r_neg_q ? -rem_q : rem_q;
    if (div0_q) begin
      quo_fix = '1;
      rem_fix = dvd_q;
    end else if (ovf_q) begin
      quo_fix = dvd_q;
      rem_fix = '0;
    end
  end

  assign result_o = rem_sel_q ? rem_fix : quo_fix;
  assign done_o   = (state_q == exu_pkg::MD_DONE);

endmodule

// ==== hw/exu_config.svh ====
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// operand and result width
`define EXU_XLEN 64

// one multiplier bit or one quotient bit per cycle
`define EXU_MD_CYCLES `EXU_XLEN

`endif

// ==== hw/exu_pkg.sv ====
package exu_pkg;

  // single-cycle ALU operations
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    // pass src2, used for lui
    ALU_PASS = 4'd5,
    ALU_XOR  = 4'd6,
    ALU_SRL  = 4'd7,
    ALU_SRA  = 4'd8,
    ALU_OR   = 4'd9,
    ALU_AND  = 4'd10
  } alu_op_e;

  // multiply group first, divide group with bit 2 set
  typedef enum logic [2:0] {
    MD_MUL    = 3'd0,
    MD_MULH   = 3'd1,
    MD_MULHSU = 3'd2,
    MD_MULHU  = 3'd3,
    MD_DIV    = 3'd4,
    MD_DIVU   = 3'd5,
    MD_REM    = 3'd6,
    MD_REMU   = 3'd7
  } md_op_e;

  // iterative unit state
  typedef enum logic [1:0] {
    MD_IDLE = 2'd0,
    MD_RUN  = 2'd1,
    MD_DONE = 2'd2
  } md_state_e;

endpackage

// ==== hw/exu_top.sv ====
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 valid_i,
  input  logic                 md_en_i,
  input  exu_pkg::alu_op_e     alu_op_i,
  input  exu_pkg::md_op_e      md_op_i,
  input  logic                 word_i,
  input  logic [`EXU_XLEN-1:0] src1_i,
  input  logic [`EXU_XLEN-1:0] src2_i,
  input  logic                 flush_i,
  output logic [`EXU_XLEN-1:0] result_o,
  output logic                 result_valid_o,
  output logic                 busy_o
);
  localparam int XLEN = `EXU_XLEN;
  localparam int HALF = XLEN / 2;

  exu_pkg::alu_op_e alu_op_q;
  exu_pkg::md_op_e  md_op_q;
  logic             word_q;
  logic [XLEN-1:0]  src1_q;
  logic [XLEN-1:0]  src2_q;
  logic             accept;
  logic             is_mul;
  logic             alu_pend_q;
  logic             mul_start_q;
  logic             div_start_q;
  logic             busy_q;
  logic             res_valid_q;
  logic             md_res_q;
  logic [XLEN-1:0]  result_q;
  logic             src1_signed;
  logic             src2_signed;
  logic [XLEN-1:0]  md_src1;
  logic [XLEN-1:0]  md_src2;
  logic [XLEN-1:0]  alu_res;
  logic             mul_done;
  logic             div_done;
  logic             md_done;
  logic [XLEN-1:0]  mul_res;
  logic [XLEN-1:0]  div_res;
  logic [XLEN-1:0]  md_raw;
  logic [XLEN-1:0]  md_res;

  // strobes while a multi-cycle op runs are dropped
  assign accept = valid_i && !busy_q;
  assign is_mul = (md_op_i == exu_pkg::MD_MUL) || (md_op_i == exu_pkg::MD_MULH) ||
                  (md_op_i == exu_pkg::MD_MULHSU) || (md_op_i == exu_pkg::MD_MULHU);

  always_ff @(posedge clk) begin
    if (accept) begin
      alu_op_q <= alu_op_i;
      md_op_q  <= md_op_i;
      word_q   <= word_i;
      src1_q   <= src1_i;
      src2_q   <= src2_i;
    end
  end

  // word operands extended per the signedness of each source
  always_comb begin
    src1_signed = (md_op_q != exu_pkg::MD_MULHU) && (md_op_q != exu_pkg::MD_DIVU) &&
                  (md_op_q != exu_pkg::MD_REMU);
    src2_signed = (md_op_q == exu_pkg::MD_MUL) || (md_op_q == exu_pkg::MD_MULH) ||
                  (md_op_q == exu_pkg::MD_DIV) || (md_op_q == exu_pkg::MD_REM);
    md_src1 = src1_q;
    md_src2 = src2_q;
    if (word_q) begin
      md_src1 = {{HALF{src1_signed & src1_q[HALF-1]}}, src1_q[HALF-1:0]};
      md_src2 = {{HALF{src2_signed & src2_q[HALF-1]}}, src2_q[HALF-1:0]};
    end
  end

  alu_core u_alu (
    .alu_op_i (alu_op_q),
    .word_i   (word_q),
    .src1_i   (src1_q),
    .src2_i   (src2_q),
    .res_o    (alu_res)
  );

  mul_iter u_mul (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (mul_start_q),
    .flush_i  (flush_i),
    .op_i     (md_op_q),
    .src1_i   (md_src1),
    .src2_i   (md_src2),
    .done_o   (mul_done),
    .result_o (mul_res)
  );

  div_iter u_div (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (div_start_q),
    .flush_i  (flush_i),
    .op_i     (md_op_q),
    .src1_i   (md_src1),
    .src2_i   (md_src2),
    .done_o   (div_done),
    .result_o (div_res)
  );

  assign md_done = (mul_done || div_done) && !flush_i;
  assign md_raw  = mul_done ? mul_res : div_res;
  assign md_res  = word_q ? {{HALF{md_raw[HALF-1]}}, md_raw[HALF-1:0]} : md_raw;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alu_pend_q  <= 1'b0;
      mul_start_q <= 1'b0;
      div_start_q <= 1'b0;
      busy_q      <= 1'b0;
      res_valid_q <= 1'b0;
      md_res_q    <= 1'b0;
    end else begin
      alu_pend_q  <= accept && !md_en_i;
      mul_start_q <= accept && md_en_i && is_mul;
      div_start_q <= accept && md_en_i && !is_mul;
      res_valid_q <= alu_pend_q || md_done;
      md_res_q    <= md_done;
      // busy covers the result cycle, a flush ends it at once
      if (accept && md_en_i) begin
        busy_q <= 1'b1;
      end else if (busy_q && (flush_i || md_res_q)) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alu_pend_q) begin
      result_q <= alu_res;
    end else if (md_done) begin
      result_q <= md_res;
    end
  end

  assign result_o       = result_q;
  assign result_valid_o = res_valid_q;
  assign busy_o         = busy_q;

endmodule

// ==== hw/mul_iter.sv ====
`timescale 1ns/1ps
`include "exu_config.svh"

module mul_iter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start_i,
  input  logic                 flush_i,
  input  exu_pkg::md_op_e      op_i,
  input  logic [`EXU_XLEN-1:0] src1_i,
  input  logic [`EXU_XLEN-1:0] src2_i,
  output logic                 done_o,
  output logic [`EXU_XLEN-1:0] result_o
);
  localparam int XLEN  = `EXU_XLEN;
  localparam int CNT_W = $clog2(`EXU_MD_CYCLES);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`EXU_MD_CYCLES - 1);

  exu_pkg::md_state_e state_q;
  logic [CNT_W-1:0]   cnt_q;
  logic [2*XLEN-1:0]  prod_q;
  logic [XLEN-1:0]    mcand_q;
  logic               neg_q;
  logic               high_q;
  logic               a_neg;
  logic               b_neg;
  logic [XLEN-1:0]    a_mag;
  logic [XLEN-1:0]    b_mag;
  logic [XLEN:0]      part_sum;
  logic [2*XLEN-1:0]  prod_fix;

  // operand magnitudes, src1 is unsigned only for mulhu
  always_comb begin
    a_neg = (op_i != exu_pkg::MD_MULHU) && src1_i[XLEN-1];
    b_neg = ((op_i == exu_pkg::MD_MUL) || (op_i == exu_pkg::MD_MULH)) && src2_i[XLEN-1];
    a_mag = a_neg ? -src1_i : src1_i;
    b_mag = b_neg ? -src2_i : src2_i;
  end

  // add multiplicand to upper half when the current multiplier bit is set
  assign part_sum = {1'b0, prod_q[2*XLEN-1:XLEN]} +
                    (prod_q[0] ? {1'b0, mcand_q} : {(XLEN+1){1'b0}});

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= exu_pkg::MD_IDLE;
      cnt_q   <= '0;
    end else if (flush_i) begin
      state_q <= exu_pkg::MD_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        exu_pkg::MD_IDLE: begin
          if (start_i) begin
            state_q <= exu_pkg::MD_RUN;
            cnt_q   <= '0;
          end
        end
        exu_pkg::MD_RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == LAST) begin
            state_q <= exu_pkg::MD_DONE;
          end
        end
        default: state_q <= exu_pkg::MD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == exu_pkg::MD_IDLE) && start_i) begin
      prod_q  <= {{XLEN{1'b0}}, b_mag};
      mcand_q <= a_mag;
      neg_q   <= a_neg ^ b_neg;
      high_q  <= (op_i != exu_pkg::MD_MUL);
    end else if (state_q == exu_pkg::MD_RUN) begin
      prod_q <= {part_sum, prod_q[XLEN-1:1]};
    end
  end

  // restore the sign on the full product before picking a half
  assign prod_fix = neg_q ? -prod_q : prod_q;
  assign result_o = high_q ? prod_fix[2*XLEN-1:XLEN] : prod_fix[XLEN-1:0];
  assign done_o   = (state_q == exu_pkg::MD_DONE);

endmodule

// ==== sim.f ====
+incdir+hw
hw/exu_pkg.sv
hw/alu_core.sv
hw/mul_iter.sv
hw/div_iter.sv
hw/exu_top.sv
sim/exu_props.sv
sim/exu_checker.sv
sim/exu_tb.sv

// ==== sim/exu_checker.sv ====
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_checker (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 valid_i,
  input  logic                 md_en_i,
  input  exu_pkg::alu_op_e     alu_op_i,
  input  exu_pkg::md_op_e      md_op_i,
  input  logic                 word_i,
  input  logic [`EXU_XLEN-1:0] src1_i,
  input  logic [`EXU_XLEN-1:0] src2_i,
  input  logic                 flush_i,
  input  logic [`EXU_XLEN-1:0] result_o,
  input  logic                 result_valid_o,
  input  logic                 busy_o,
  input  logic                 exp_use_i,
  input  logic [`EXU_XLEN-1:0] exp_val_i,
  output int                   err_cnt_o,
  output int                   pending_o,
  output int                   unexpected_o
);
  logic [`EXU_XLEN-1:0] exp_q[$];
  int                   lat_q[$];
  int                   acc_q[$];
  int                   cyc;
  int                   bsy_cnt;
  logic [`EXU_XLEN-1:0] exp_v;
  int                   lat_v;
  int                   acc_v;

  function automatic logic [63:0] sext_word(input logic [63:0] v);
    return {{32{v[31]}}, v[31:0]};
  endfunction

  function automatic logic [63:0] ref_alu(input exu_pkg::alu_op_e op, input logic w,
                                          input logic [63:0] a, input logic [63:0] b);
    logic [63:0] r;
    case (op)
      exu_pkg::ALU_ADD:  r = a + b;
      exu_pkg::ALU_SUB:  r = a - b;
      exu_pkg::ALU_SLL:  r = w ? (a << b[4:0]) : (a << b[5:0]);
      exu_pkg::ALU_SLT:  r = w ? 64'($signed(a[31:0]) < $signed(b[31:0])) :
                                 64'($signed(a) < $signed(b));
      exu_pkg::ALU_SLTU: r = w ? 64'(a[31:0] < b[31:0]) : 64'(a < b);
      exu_pkg::ALU_PASS: r = b;
      exu_pkg::ALU_XOR:  r = a ^ b;
      exu_pkg::ALU_SRL:  r = w ? 64'(a[31:0] >> b[4:0]) : (a >> b[5:0]);
      exu_pkg::ALU_SRA:  r = w ? 64'($signed(a[31:0]) >>> b[4:0]) : ($signed(a) >>> b[5:0]);
      exu_pkg::ALU_OR:   r = a | b;
      default:           r = a & b;
    endcase
    return w ? sext_word(r) : r;
  endfunction

  function automatic logic [63:0] ref_md(input exu_pkg::md_op_e op, input logic w,
                                         input logic [63:0] a, input logic [63:0] b);
    logic               a_s;
    logic               b_s;
    logic [63:0]        ea;
    logic [63:0]        eb;
    logic [127:0]       p;
    logic signed [63:0] q;
    logic signed [63:0] rm;
    logic [63:0]        r;
    a_s = (op != exu_pkg::MD_MULHU) && (op != exu_pkg::MD_DIVU) && (op != exu_pkg::MD_REMU);
    b_s = (op == exu_pkg::MD_MUL) || (op == exu_pkg::MD_MULH) ||
          (op == exu_pkg::MD_DIV) || (op == exu_pkg::MD_REM);
    ea = w ? (a_s ? sext_word(a) : {32'd0, a[31:0]}) : a;
    eb = w ? (b_s ? sext_word(b) : {32'd0, b[31:0]}) : b;
    p  = {{64{a_s & ea[63]}}, ea} * {{64{b_s & eb[63]}}, eb};
    if (eb == '0) begin
      q  = '1;
      rm = ea;
    end else if (b_s && !w && (ea == {1'b1, 63'd0}) && (eb == '1)) begin
      // signed overflow
      q  = ea;
      rm = '0;
    end else if (b_s) begin
      q  = $signed(ea) / $signed(eb);
      rm = $signed(ea) % $signed(eb);
    end else begin
      q  = ea / eb;
      rm = ea % eb;
    end
    case (op)
      exu_pkg::MD_MUL:                    r = p[63:0];
      exu_pkg::MD_DIV, exu_pkg::MD_DIVU: r = q;
      exu_pkg::MD_REM, exu_pkg::MD_REMU: r = rm;
      default:                            r = p[127:64];
    endcase
    return w ? sext_word(r) : r;
  endfunction

  initial begin
    cyc          = 0;
    bsy_cnt      = 0;
    err_cnt_o    = 0;
    pending_o    = 0;
    unexpected_o = 0;
  end

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (rst_n) begin
      if (result_valid_o) begin
        if (exp_q.size() == 0) begin
          unexpected_o = unexpected_o + 1;
          $display("result strobe at %0t with no operation outstanding", $time);
        end else begin
          exp_v = exp_q.pop_front();
          lat_v = lat_q.pop_front();
          acc_v = acc_q.pop_front();
          if (result_o !== exp_v) begin
            err_cnt_o = err_cnt_o + 1;
            $display("ERROR %0t: result %h, expected %h", $time, result_o, exp_v);
          end
          // strobe seen one edge after it was registered
          if (cyc - acc_v - 1 != lat_v) begin
            err_cnt_o = err_cnt_o + 1;
            $display("ERROR %0t: latency %0d, expected %0d", $time, cyc - acc_v - 1, lat_v);
          end
        end
      end
      // busy from the cycle after a multi-cycle issue through its result cycle
      if (busy_o !== (bsy_cnt != 0)) begin
        err_cnt_o = err_cnt_o + 1;
        $display("ERROR %0t: busy %b, expected %b", $time, busy_o, bsy_cnt != 0);
      end
      if (bsy_cnt != 0) begin
        bsy_cnt = flush_i ? 0 : bsy_cnt - 1;
      end
      // aborted operation produces nothing
      if (flush_i && busy_o && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
        void'(lat_q.pop_front());
        void'(acc_q.pop_front());
      end
      if (valid_i && !busy_o) begin
        if (exp_use_i) begin
          exp_q.push_back(exp_val_i);
        end else if (md_en_i) begin
          exp_q.push_back(ref_md(md_op_i, word_i, src1_i, src2_i));
        end else begin
          exp_q.push_back(ref_alu(alu_op_i, word_i, src1_i, src2_i));
        end
        lat_q.push_back(md_en_i ? `EXU_MD_CYCLES + 2 : 1);
        acc_q.push_back(cyc);
        // one cycle past the result latency
        if (md_en_i) begin
          bsy_cnt = `EXU_MD_CYCLES + 3;
        end
      end
      pending_o = exp_q.size();
    end
  end

endmodule

// ==== sim/exu_props.sv ====
`timescale 1ns/1ps

module exu_props (
  input logic clk,
  input logic rst_n,
  input logic valid_i,
  input logic flush_i,
  input logic result_valid_o,
  input logic busy_o
);

  // failed assertion count
  int fail_cnt = 0;

  // outputs held low during reset
  reset_quiet: assert property (@(posedge clk) !rst_n |-> (!busy_o && !result_valid_o))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("busy or result strobe high during reset");
    end

  strobe_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid_o |=> !result_valid_o)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("result strobe longer than one cycle");
    end

  no_issue_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
    !(valid_i && busy_o))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("issue strobe while unit busy");
    end

  flush_clears_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (flush_i && busy_o) |=> !busy_o)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("busy still high after flush");
    end

endmodule

// ==== sim/exu_tb.sv ====
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_tb;
  localparam int N_MAX = 96;

  logic                 clk;
  logic                 rst_n;
  logic                 valid_i;
  logic                 md_en_i;
  exu_pkg::alu_op_e     alu_op_i;
  exu_pkg::md_op_e      md_op_i;
  logic                 word_i;
  logic [`EXU_XLEN-1:0] src1_i;
  logic [`EXU_XLEN-1:0] src2_i;
  logic                 flush_i;
  logic [`EXU_XLEN-1:0] result_o;
  logic                 result_valid_o;
  logic                 busy_o;
  logic                 exp_use;
  logic [`EXU_XLEN-1:0] exp_val;
  int                   err_cnt;
  int                   pending;
  int                   unexpected;

  // stimulus table
  logic                 md_t[N_MAX];
  int                   op_t[N_MAX];
  logic                 w_t[N_MAX];
  logic [`EXU_XLEN-1:0] a_t[N_MAX];
  logic [`EXU_XLEN-1:0] b_t[N_MAX];
  int                   fl_t[N_MAX];
  logic                 use_t[N_MAX];
  logic [`EXU_XLEN-1:0] exp_t[N_MAX];
  int                   n_ent;
  int                   cyc;
  int                   limit;

  exu_top dut_i (
    .clk(clk), .rst_n(rst_n), .valid_i(valid_i), .md_en_i(md_en_i), .alu_op_i(alu_op_i),
    .md_op_i(md_op_i), .word_i(word_i), .src1_i(src1_i), .src2_i(src2_i), .flush_i(flush_i),
    .result_o(result_o), .result_valid_o(result_valid_o), .busy_o(busy_o)
  );

  exu_checker u_chk (
    .clk(clk), .rst_n(rst_n), .valid_i(valid_i), .md_en_i(md_en_i), .alu_op_i(alu_op_i),
    .md_op_i(md_op_i), .word_i(word_i), .src1_i(src1_i), .src2_i(src2_i), .flush_i(flush_i),
    .result_o(result_o), .result_valid_o(result_valid_o), .busy_o(busy_o),
    .exp_use_i(exp_use), .exp_val_i(exp_val), .err_cnt_o(err_cnt), .pending_o(pending),
    .unexpected_o(unexpected)
  );

  bind exu_top exu_props u_props (
    .clk(clk), .rst_n(rst_n), .valid_i(valid_i), .flush_i(flush_i),
    .result_valid_o(result_valid_o), .busy_o(busy_o)
  );

  always #20 clk = ~clk;

  task automatic add_entry(input logic md, input int op, input logic w, input logic [63:0] a,
                           input logic [63:0] b, input int fl, input logic [63:0] exp);
    md_t[n_ent]  = md;
    op_t[n_ent]  = op;
    w_t[n_ent]   = w;
    a_t[n_ent]   = a;
    b_t[n_ent]   = b;
    fl_t[n_ent]  = fl;
    use_t[n_ent] = 1'b1;
    exp_t[n_ent] = exp;
    n_ent = n_ent + 1;
  endtask

  task automatic add_random();
    md_t[n_ent]  = $urandom % 2;
    op_t[n_ent]  = md_t[n_ent] ? ($urandom % 8) : ($urandom % 11);
    w_t[n_ent]   = $urandom % 2;
    // no word form of the high multiplies
    if (md_t[n_ent] && op_t[n_ent] >= 1 && op_t[n_ent] <= 3) begin
      w_t[n_ent] = 1'b0;
    end
    a_t[n_ent]   = {$urandom, $urandom};
    b_t[n_ent]   = ($urandom % 4 == 0) ? 64'($urandom % 8) : {$urandom, $urandom};
    fl_t[n_ent]  = 0;
    use_t[n_ent] = 1'b0;
    exp_t[n_ent] = '0;
    n_ent = n_ent + 1;
  endtask

  task automatic run_entry(input int i);
    @(negedge clk);
    valid_i  = 1'b1;
    md_en_i  = md_t[i];
    alu_op_i = md_t[i] ? exu_pkg::ALU_ADD : exu_pkg::alu_op_e'(op_t[i][3:0]);
    md_op_i  = exu_pkg::md_op_e'(op_t[i][2:0]);
    word_i   = w_t[i];
    src1_i   = a_t[i];
    src2_i   = b_t[i];
    exp_use  = use_t[i];
    exp_val  = exp_t[i];
    @(negedge clk);
    valid_i = 1'b0;
    if (fl_t[i] > 0) begin
      repeat (fl_t[i] - 1) @(negedge clk);
      flush_i = 1'b1;
      @(negedge clk);
      flush_i = 1'b0;
      @(negedge clk);
    end else begin
      while (!result_valid_o) @(negedge clk);
      while (busy_o) @(negedge clk);
    end
  endtask

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc > limit) begin
      $display("run stopped after %0d cycles without finishing the tests", cyc);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    valid_i = 1'b0;
    md_en_i = 1'b0;
    alu_op_i = exu_pkg::ALU_ADD;
    md_op_i = exu_pkg::MD_MUL;
    word_i = 1'b0;
    src1_i = '0;
    src2_i = '0;
    flush_i = 1'b0;
    exp_use = 1'b0;
    exp_val = '0;
    n_ent = 0;
    cyc = 0;
    void'($urandom(32'ha5c5_0513));
    add_entry(0, exu_pkg::ALU_ADD,  0, 64'd5, 64'd7, 0, 64'hc);
    add_entry(0, exu_pkg::ALU_ADD,  1, 64'h7fff_ffff, 64'd1, 0, 64'hffff_ffff_8000_0000);
    add_entry(0, exu_pkg::ALU_SUB,  0, 64'd3, 64'd5, 0, 64'hffff_ffff_ffff_fffe);
    add_entry(0, exu_pkg::ALU_SUB,  1, 64'h1_0000_0000, 64'd1, 0, '1);
    add_entry(0, exu_pkg::ALU_SLL,  0, 64'h1234, 64'd0, 0, 64'h1234);
    add_entry(0, exu_pkg::ALU_SLL,  0, 64'd1, 64'd63, 0, 64'h8000_0000_0000_0000);
    add_entry(0, exu_pkg::ALU_SLL,  1, 64'd1, 64'd31, 0, 64'hffff_ffff_8000_0000);
    add_entry(0, exu_pkg::ALU_SLL,  0, 64'd1, 64'd32, 0, 64'h1_0000_0000);
    add_entry(0, exu_pkg::ALU_SLT,  0, '1, 64'd1, 0, 64'd1);
    add_entry(0, exu_pkg::ALU_SLTU, 0, '1, 64'd1, 0, 64'd0);
    add_entry(0, exu_pkg::ALU_SLT,  1, 64'h8000_0000, 64'd0, 0, 64'd1);
    add_entry(0, exu_pkg::ALU_PASS, 1, 64'd9, 64'h8000_0000, 0, 64'hffff_ffff_8000_0000);
    add_entry(0, exu_pkg::ALU_XOR,  0, 64'hff00, 64'h0ff0, 0, 64'hf0f0);
    add_entry(0, exu_pkg::ALU_SRL,  0, 64'h8000_0000_0000_0000, 64'd63, 0, 64'd1);
    add_entry(0, exu_pkg::ALU_SRL,  1, 64'hffff_ffff_8000_0000, 64'd31, 0, 64'd1);
    add_entry(0, exu_pkg::ALU_SRA,  0, 64'h8000_0000_0000_0000, 64'd32, 0,
              64'hffff_ffff_8000_0000);
    add_entry(0, exu_pkg::ALU_SRA,  1, 64'hf000_0000, 64'd4, 0, 64'hffff_ffff_ff00_0000);
    add_entry(0, exu_pkg::ALU_OR,   0, 64'hf0, 64'h0f, 0, 64'hff);
    add_entry(0, exu_pkg::ALU_AND,  0, 64'hf0f0, 64'hff00, 0, 64'hf000);
    add_entry(1, exu_pkg::MD_MUL,    0, 64'd7, 64'd6, 0, 64'h2a);
    add_entry(1, exu_pkg::MD_MULH,   0, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 0,
              64'h4000_0000_0000_0000);
    add_entry(1, exu_pkg::MD_MULHU,  0, '1, '1, 0, 64'hffff_ffff_ffff_fffe);
    add_entry(1, exu_pkg::MD_MULHSU, 0, '1, 64'd2, 0, '1);
    add_entry(1, exu_pkg::MD_MUL,    1, 64'h7fff_ffff, 64'd2, 0, 64'hffff_ffff_ffff_fffe);
    add_entry(1, exu_pkg::MD_DIV,    0, -64'd7, 64'd2, 0, 64'hffff_ffff_ffff_fffd);
    add_entry(1, exu_pkg::MD_REM,    0, -64'd7, 64'd2, 0, '1);
    add_entry(1, exu_pkg::MD_DIVU,   0, 64'd5, 64'd0, 0, '1);
    add_entry(1, exu_pkg::MD_REMU,   0, 64'd5, 64'd0, 0, 64'd5);
    add_entry(1, exu_pkg::MD_DIV,    0, 64'h8000_0000_0000_0000, '1, 0, 64'h8000_0000_0000_0000);
    add_entry(1, exu_pkg::MD_REM,    0, 64'h8000_0000_0000_0000, '1, 0, 64'd0);
    add_entry(1, exu_pkg::MD_DIV,    1, 64'h8000_0000, 64'hffff_ffff, 0, 64'hffff_ffff_8000_0000);
    add_entry(1, exu_pkg::MD_REM,    1, 64'h8000_0003, 64'd0, 0, 64'hffff_ffff_8000_0003);
    // aborted operations, each followed by an ALU op
    add_entry(1, exu_pkg::MD_MUL,    0, 64'd3, 64'd3, 10, 64'd0);
    add_entry(0, exu_pkg::ALU_ADD,   0, 64'd1, 64'd1, 0, 64'd2);
    add_entry(1, exu_pkg::MD_DIV,    0, 64'd100, 64'd7, 3, 64'd0);
    add_entry(0, exu_pkg::ALU_ADD,   0, 64'd100, 64'd23, 0, 64'h7b);
    repeat (40) add_random();
    limit = n_ent * 70 + 100;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < n_ent; i++) begin
      run_entry(i);
    end
    repeat (4) @(negedge clk);
    $display("errors %0d, missing results %0d, unexpected results %0d, assertion failures %0d",
             err_cnt, pending, unexpected, dut_i.u_props.fail_cnt);
    if (err_cnt == 0 && pending == 0 && unexpected == 0 && dut_i.u_props.fail_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
